// ==== compile.f ====
hdl/zx81_pkg.sv
hdl/zx81_boot_rom.sv
hdl/zx81_tape_buffer.sv
hdl/zx81_tape_loader.sv
hdl/zx81_shared_ram.sv
hdl/zx81_address_map.sv
hdl/zx81_memory_top.sv
verification/zx81_bus_assertions.sv
verification/zx81_memory_tb.sv

// ==== hdl/zx81_address_map.sv ====
`timescale 1ns/1ps

module zx81_address_map (
	input  logic                clk_sys,
	input  logic                reset,
	input  zx81_pkg::mem_size_t mem_size,
	input  zx81_pkg::cpu_req_t  cpu_req,
	input  zx81_pkg::bus_rsp_t  ram_rsp,
	input  logic [7:0]          rom_dat,
	input  logic [7:0]          patch_dat,
	input  logic                loader_active,
	output zx81_pkg::bus_rsp_t  cpu_rsp,
	output zx81_pkg::ram_req_t  ram_req,
	output logic [15:0]         cpu_adr,
	output logic                cpu_fetch_strobe
);

	zx81_pkg::mem_size_t mem_size_q;
	logic        req_valid;
	logic        busy_q;
	logic        first_cycle;
	logic        local_ack;
	logic        big_ram;
	logic        patch_hit;
	logic        rom_hit;
	logic        ram_hit;
	logic [15:0] ram_adr;

	// Size only changes across a reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_size_q <= mem_size;
		end
	end

	assign cpu_adr          = cpu_req.adr;
	assign req_valid        = cpu_req.cyc & cpu_req.stb;
	assign first_cycle      = req_valid & ~busy_q;
	assign cpu_fetch_strobe = first_cycle & cpu_req.fetch;

	// ==================================================
	// Decode
	// ==================================================

	assign big_ram = (mem_size_q == zx81_pkg::MEM_32K) || (mem_size_q == zx81_pkg::MEM_48K);

	assign patch_hit = loader_active & ~cpu_req.we
		& (cpu_adr >= zx81_pkg::LOAD_ENTRY_ADDR)
		& (cpu_adr < zx81_pkg::LOAD_ENTRY_ADDR + 16'(zx81_pkg::PATCH_LEN));

	// ROM at 0000h, mirrored at 8000h unless that space is RAM
	assign rom_hit = (cpu_adr[15:13] == 3'b000) | ((cpu_adr[15:13] == 3'b100) & ~big_ram);
	assign ram_hit = ~rom_hit & (cpu_adr[14] | (cpu_adr[15] & big_ram));

	always_comb begin
		case (mem_size_q)
			zx81_pkg::MEM_1K:  ram_adr = {6'b010000, cpu_adr[9:0]};
			zx81_pkg::MEM_16K: ram_adr = {2'b01, cpu_adr[13:0]};
			zx81_pkg::MEM_32K: begin
				if (cpu_adr[15:14] == 2'b10) begin
					ram_adr = {2'b10, cpu_adr[13:0]};
				end else begin
					ram_adr = {2'b01, cpu_adr[13:0]};
				end
			end
			default: begin
				// Top bank is data only, fetches see main RAM
				case (cpu_adr[15:14])
					2'b10:   ram_adr = {2'b10, cpu_adr[13:0]};
					2'b11:   ram_adr = {~cpu_req.fetch, 1'b1, cpu_adr[13:0]};
					default: ram_adr = {2'b01, cpu_adr[13:0]};
				endcase
			end
		endcase
	end

	// ==================================================
	// Handshake
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy_q    <= 1'b0;
			local_ack <= 1'b0;
		end else begin
			busy_q    <= req_valid & ~cpu_rsp.ack;
			local_ack <= first_cycle & ~ram_hit;
		end
	end

	assign ram_req.cyc = cpu_req.cyc & ram_hit;
	assign ram_req.stb = cpu_req.stb & ram_hit;
	assign ram_req.we  = cpu_req.we;
	assign ram_req.adr = ram_adr;
	assign ram_req.dat = cpu_req.dat;

	assign cpu_rsp.ack = local_ack | ram_rsp.ack;

	always_comb begin
		if (ram_hit) begin
			cpu_rsp.dat = ram_rsp.dat;
		end else if (patch_hit) begin
			cpu_rsp.dat = patch_dat;
		end else if (rom_hit) begin
			cpu_rsp.dat = rom_dat;
		end else begin
			cpu_rsp.dat = 8'hFF;
		end
	end

endmodule

// ==== hdl/zx81_boot_rom.sv ====
`timescale 1ns/1ps

module zx81_boot_rom (
	input  logic        clk_sys,
	input  logic [12:0] rd_adr,
	output logic [7:0]  rd_dat,
	input  logic        wr_en,
	input  logic [12:0] wr_adr,
	input  logic [7:0]  wr_dat
);

	logic [7:0] mem [8192];

	// Loaded from the download port only
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_adr] <= wr_dat;
		end
	end

	// Registered read for the CPU side
	always_ff @(posedge clk_sys) begin
		rd_dat <= mem[rd_adr];
	end

endmodule

// ==== hdl/zx81_memory_top.sv ====
`timescale 1ns/1ps

module zx81_memory_top #(
	parameter int TAPE_DEPTH = 16384
) (
	input  logic                clk_sys,
	input  logic                reset,
	input  zx81_pkg::mem_size_t mem_size,
	input  zx81_pkg::cpu_req_t  cpu_req,
	output zx81_pkg::bus_rsp_t  cpu_rsp,
	input  zx81_pkg::dl_req_t   dl_req,
	output logic                dl_ack,
	output logic                tape_ready
);

	localparam int TAPE_AW = $clog2(TAPE_DEPTH);

	zx81_pkg::ram_req_t ram_req_cpu;
	zx81_pkg::ram_req_t ram_req_tape;
	zx81_pkg::bus_rsp_t ram_rsp_cpu;
	zx81_pkg::bus_rsp_t ram_rsp_tape;

	logic [15:0]        cpu_adr;
	logic               cpu_fetch_strobe;
	logic [7:0]         rom_dat;
	logic [7:0]         patch_dat;
	logic               loader_active;

	logic               rom_wr_en;
	logic [12:0]        rom_wr_adr;
	logic [7:0]         rom_wr_dat;

	logic [TAPE_AW-1:0] tape_rd_adr;
	logic [7:0]         tape_rd_dat;
	logic [TAPE_AW:0]   tape_size;

	zx81_address_map map0 (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.mem_size         (mem_size),
		.cpu_req          (cpu_req),
		.ram_rsp          (ram_rsp_cpu),
		.rom_dat          (rom_dat),
		.patch_dat        (patch_dat),
		.loader_active    (loader_active),
		.cpu_rsp          (cpu_rsp),
		.ram_req          (ram_req_cpu),
		.cpu_adr          (cpu_adr),
		.cpu_fetch_strobe (cpu_fetch_strobe)
	);

	zx81_boot_rom rom0 (
		.clk_sys (clk_sys),
		.rd_adr  (cpu_adr[12:0]),
		.rd_dat  (rom_dat),
		.wr_en   (rom_wr_en),
		.wr_adr  (rom_wr_adr),
		.wr_dat  (rom_wr_dat)
	);

	zx81_tape_buffer #(
		.TAPE_DEPTH (TAPE_DEPTH)
	) tape0 (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_req      (dl_req),
		.dl_ack      (dl_ack),
		.rom_wr_en   (rom_wr_en),
		.rom_wr_adr  (rom_wr_adr),
		.rom_wr_dat  (rom_wr_dat),
		.tape_rd_adr (tape_rd_adr),
		.tape_rd_dat (tape_rd_dat),
		.tape_size   (tape_size),
		.tape_ready  (tape_ready)
	);

	zx81_tape_loader #(
		.TAPE_DEPTH (TAPE_DEPTH)
	) loader0 (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.cpu_adr          (cpu_adr),
		.cpu_fetch_strobe (cpu_fetch_strobe),
		.patch_dat        (patch_dat),
		.loader_active    (loader_active),
		.tape_rd_adr      (tape_rd_adr),
		.tape_rd_dat      (tape_rd_dat),
		.tape_size        (tape_size),
		.ram_req          (ram_req_tape),
		.ram_rsp          (ram_rsp_tape)
	);

	// CPU on port 0 has priority over the copier
	zx81_shared_ram ram0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.req0    (ram_req_cpu),
		.req1    (ram_req_tape),
		.rsp0    (ram_rsp_cpu),
		.rsp1    (ram_rsp_tape)
	);

endmodule

// ==== hdl/zx81_pkg.sv ====
package zx81_pkg;

	// ==================================================
	// Configuration
	// ==================================================

	// Main RAM fitted
	typedef enum logic [1:0] {
		MEM_1K,
		MEM_16K,
		MEM_32K,
		MEM_48K
	} mem_size_t;

	// Download destination
	typedef enum logic {
		DL_ROM,
		DL_TAPE
	} dl_target_t;

	// ==================================================
	// Bus structs
	// ==================================================

	// CPU side request, fetch marks an opcode fetch (M1)
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic        fetch;
		logic [15:0] adr;
		logic [7:0]  dat;
	} cpu_req_t;

	// Response shared by the CPU port and the RAM ports
	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} bus_rsp_t;

	// Master request into the shared RAM, physical address
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [15:0] adr;
		logic [7:0]  dat;
	} ram_req_t;

	// Download port, write only
	typedef struct packed {
		logic        cyc;
		logic        stb;
		dl_target_t  target;
		logic        last;
		logic [13:0] adr;
		logic [7:0]  dat;
	} dl_req_t;

	// ==================================================
	// Memory map and loader patch
	// ==================================================

	localparam logic [15:0] LOAD_ENTRY_ADDR = 16'h0347;
	localparam logic [15:0] LOAD_EXIT_ADDR  = 16'h03C3;
	localparam logic [15:0] TAPE_RAM_BASE   = 16'h4009;

	// xor a / nop or scf / jr nc back / jp 0207h
	localparam int PATCH_LEN = 7;
	localparam logic [7:0] PATCH_INIT [PATCH_LEN] = '{
		8'hAF, 8'h00, 8'h30, 8'hFD, 8'hC3, 8'h07, 8'h02
	};
	localparam logic [7:0] PATCH_SCF = 8'h37;

endpackage

// ==== hdl/zx81_shared_ram.sv ====
`timescale 1ns/1ps

module zx81_shared_ram (
	input  logic               clk_sys,
	input  logic               reset,
	input  zx81_pkg::ram_req_t req0,
	input  zx81_pkg::ram_req_t req1,
	output zx81_pkg::bus_rsp_t rsp0,
	output zx81_pkg::bus_rsp_t rsp1
);

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_ACCESS,
		ARB_ACK
	} arb_state_t;

	arb_state_t         state;
	logic               gnt1;
	logic               gnt_live;
	zx81_pkg::ram_req_t gnt_req;
	logic [7:0]         rd_q;
	logic [7:0]         mem [65536];

	assign gnt_req  = gnt1 ? req1 : req0;
	assign gnt_live = gnt_req.cyc & gnt_req.stb;

	// ==================================================
	// Arbiter
	// ==================================================

	// Grant is held through access and ack, then rearbitrated
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ARB_IDLE;
			gnt1  <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (req0.cyc & req0.stb) begin
						gnt1  <= 1'b0;
						state <= ARB_ACCESS;
					end else if (req1.cyc & req1.stb) begin
						gnt1  <= 1'b1;
						state <= ARB_ACCESS;
					end
				end
				ARB_ACCESS: state <= gnt_live ? ARB_ACK : ARB_IDLE;
				ARB_ACK:    state <= ARB_IDLE;
				default:    state <= ARB_IDLE;
			endcase
		end
	end

	// ==================================================
	// RAM array
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if ((state == ARB_ACCESS) && gnt_live) begin
			if (gnt_req.we) begin
				mem[gnt_req.adr] <= gnt_req.dat;
			end
			rd_q <= mem[gnt_req.adr];
		end
	end

	assign rsp0.ack = (state == ARB_ACK) & ~gnt1;
	assign rsp0.dat = rd_q;
	assign rsp1.ack = (state == ARB_ACK) & gnt1;
	assign rsp1.dat = rd_q;

endmodule

// ==== hdl/zx81_tape_buffer.sv ====
`timescale 1ns/1ps

module zx81_tape_buffer #(
	parameter int TAPE_DEPTH = 16384
) (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  zx81_pkg::dl_req_t              dl_req,
	output logic                           dl_ack,
	output logic                           rom_wr_en,
	output logic [12:0]                    rom_wr_adr,
	output logic [7:0]                     rom_wr_dat,
	input  logic [$clog2(TAPE_DEPTH)-1:0]  tape_rd_adr,
	output logic [7:0]                     tape_rd_dat,
	output logic [$clog2(TAPE_DEPTH):0]    tape_size,
	output logic                           tape_ready
);

	localparam int TAPE_AW = $clog2(TAPE_DEPTH);

	logic [7:0]         tape_mem [TAPE_DEPTH];
	logic               wr_fire;
	logic               tape_wr;
	logic [TAPE_AW-1:0] tape_wr_adr;

	// Ack one cycle after the request shows up
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_ack <= 1'b0;
		end else begin
			dl_ack <= dl_req.cyc & dl_req.stb & ~dl_ack;
		end
	end

	// Write happens in the ack cycle, request is still held
	assign wr_fire = dl_ack & dl_req.cyc & dl_req.stb;

	assign rom_wr_en  = wr_fire & (dl_req.target == zx81_pkg::DL_ROM);
	assign rom_wr_adr = dl_req.adr[12:0];
	assign rom_wr_dat = dl_req.dat;

	assign tape_wr     = wr_fire & (dl_req.target == zx81_pkg::DL_TAPE);
	assign tape_wr_adr = dl_req.adr[TAPE_AW-1:0];

	// ==================================================
	// Tape image store
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (tape_wr) begin
			tape_mem[tape_wr_adr] <= dl_req.dat;
		end
		tape_rd_dat <= tape_mem[tape_rd_adr];
	end

	// Length comes from the last byte written
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tape_size <= '0;
		end else if (tape_wr & dl_req.last) begin
			tape_size <= {1'b0, tape_wr_adr} + 1'b1;
		end
	end

	assign tape_ready = |tape_size;

endmodule

// ==== hdl/zx81_tape_loader.sv ====
`timescale 1ns/1ps

module zx81_tape_loader #(
	parameter int TAPE_DEPTH = 16384
) (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic [15:0]                    cpu_adr,
	input  logic                           cpu_fetch_strobe,
	output logic [7:0]                     patch_dat,
	output logic                           loader_active,
	output logic [$clog2(TAPE_DEPTH)-1:0]  tape_rd_adr,
	input  logic [7:0]                     tape_rd_dat,
	input  logic [$clog2(TAPE_DEPTH):0]    tape_size,
	output zx81_pkg::ram_req_t             ram_req,
	input  zx81_pkg::bus_rsp_t             ram_rsp
);

	localparam int TAPE_AW = $clog2(TAPE_DEPTH);

	logic [TAPE_AW:0] idx;
	logic             busy;
	logic             rewind;
	logic [7:0]       patch_b1;
	logic [15:0]      patch_ofs;
	logic             entry_hit;
	logic             exit_hit;

	assign entry_hit = cpu_fetch_strobe & (cpu_adr == zx81_pkg::LOAD_ENTRY_ADDR);
	assign exit_hit  = cpu_fetch_strobe
		& ((cpu_adr >= zx81_pkg::LOAD_EXIT_ADDR) | (cpu_adr < zx81_pkg::LOAD_ENTRY_ADDR));

	// ==================================================
	// Copy engine
	// ==================================================

	// Index stays put during a write so address and data hold until ack
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			loader_active <= 1'b0;
			busy          <= 1'b0;
			rewind        <= 1'b0;
			idx           <= '0;
			patch_b1      <= zx81_pkg::PATCH_INIT[1];
		end else begin
			if (busy) begin
				if (ram_rsp.ack) begin
					busy <= 1'b0;
					idx  <= idx + 1'b1;
				end
			end else if (rewind) begin
				idx    <= '0;
				rewind <= 1'b0;
			end else if (loader_active) begin
				if (idx < tape_size) begin
					busy <= 1'b1;
				end else begin
					// Tape done, the ROM loop falls through
					patch_b1 <= zx81_pkg::PATCH_SCF;
				end
			end

			// Entry wins over the copy updates above
			if (entry_hit) begin
				loader_active <= 1'b1;
				patch_b1      <= 8'h00;
				rewind        <= 1'b1;
			end
			if (exit_hit) begin
				loader_active <= 1'b0;
			end
		end
	end

	assign tape_rd_adr = idx[TAPE_AW-1:0];

	// One byte per grant, tape data is valid from the first busy cycle
	assign ram_req.cyc = busy;
	assign ram_req.stb = busy;
	assign ram_req.we  = 1'b1;
	assign ram_req.adr = zx81_pkg::TAPE_RAM_BASE + 16'(idx);
	assign ram_req.dat = tape_rd_dat;

	// ==================================================
	// Patch bytes
	// ==================================================

	assign patch_ofs = cpu_adr - zx81_pkg::LOAD_ENTRY_ADDR;

	always_comb begin
		if (patch_ofs == 16'd1) begin
			patch_dat = patch_b1;
		end else if (patch_ofs < 16'(zx81_pkg::PATCH_LEN)) begin
			patch_dat = zx81_pkg::PATCH_INIT[patch_ofs[2:0]];
		end else begin
			patch_dat = 8'hFF;
		end
	end

endmodule

// ==== verification/zx81_bus_assertions.sv ====
`timescale 1ns/1ps

module zx81_bus_assertions (
	input logic               clk_sys,
	input logic               reset,
	input zx81_pkg::ram_req_t req0,
	input zx81_pkg::ram_req_t req1,
	input zx81_pkg::bus_rsp_t rsp0,
	input zx81_pkg::bus_rsp_t rsp1
);

	// Number of failed protocol checks
	int unsigned fail_count = 0;

	// ==================================================
	// Port 0 from the CPU side
	// ==================================================

	ack0_in_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		rsp0.ack |-> (req0.cyc && req0.stb))
		else begin
			$error("Port 0 ack without cyc and stb");
			fail_count++;
		end

	ack0_single: assert property (@(posedge clk_sys) disable iff (reset)
		rsp0.ack |=> !rsp0.ack)
		else begin
			$error("Port 0 ack longer than one cycle");
			fail_count++;
		end

	req0_held: assert property (@(posedge clk_sys) disable iff (reset)
		(req0.cyc && req0.stb && !rsp0.ack) |=> $stable(req0))
		else begin
			$error("Port 0 request changed before ack");
			fail_count++;
		end

	// ==================================================
	// Port 1 from the tape copier
	// ==================================================

	ack1_in_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		rsp1.ack |-> (req1.cyc && req1.stb))
		else begin
			$error("Port 1 ack without cyc and stb");
			fail_count++;
		end

	ack1_single: assert property (@(posedge clk_sys) disable iff (reset)
		rsp1.ack |=> !rsp1.ack)
		else begin
			$error("Port 1 ack longer than one cycle");
			fail_count++;
		end

	req1_held: assert property (@(posedge clk_sys) disable iff (reset)
		(req1.cyc && req1.stb && !rsp1.ack) |=> $stable(req1))
		else begin
			$error("Port 1 request changed before ack");
			fail_count++;
		end

	// Nothing acks while the arbiter sits in reset
	quiet_in_reset: assert property (@(posedge clk_sys)
		$past(reset) |-> !(rsp0.ack || rsp1.ack))
		else begin
			$error("Ack seen during reset");
			fail_count++;
		end

endmodule

// ==== verification/zx81_memory_tb.sv ====
`timescale 1ns/1ps

module zx81_memory_tb;

	localparam int TAPE_LEN = 24;

	typedef enum logic [2:0] {
		S_RESET,
		S_LOAD_ROM,
		S_LOAD_TAPE,
		S_READY,
		S_READ,
		S_WRITE,
		S_FETCH,
		S_POLL
	} step_kind_t;

	// One table row where dat holds the size for a reset row
	typedef struct packed {
		step_kind_t  kind;
		logic [15:0] adr;
		logic [7:0]  dat;
		logic [7:0]  exp;
	} step_t;

	logic                clk_sys;
	logic                reset;
	zx81_pkg::mem_size_t mem_size;
	zx81_pkg::cpu_req_t  cpu_req;
	zx81_pkg::bus_rsp_t  cpu_rsp;
	zx81_pkg::dl_req_t   dl_req;
	logic                dl_ack;
	logic                tape_ready;

	step_t       steps[$];
	logic [7:0]  tape_img [TAPE_LEN];
	logic [31:0] lfsr = 32'h1dabfd85;
	logic        table_built = 1'b0;

	zx81_memory_top #(
		.TAPE_DEPTH (16384)
	) dut0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mem_size   (mem_size),
		.cpu_req    (cpu_req),
		.cpu_rsp    (cpu_rsp),
		.dl_req     (dl_req),
		.dl_ack     (dl_ack),
		.tape_ready (tape_ready)
	);

	bind zx81_shared_ram zx81_bus_assertions bus_chk0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.req0    (req0),
		.req1    (req1),
		.rsp0    (rsp0),
		.rsp1    (rsp1)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Helpers
	// ==================================================

	task automatic stop_run();
		$display("Something failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check_rsp(input logic [15:0] adr, input zx81_pkg::bus_rsp_t got,
		input zx81_pkg::bus_rsp_t want);
		if (got !== want) begin
			$display("Mismatch at time %0t: cpu_rsp.dat at %04hh got %02h expected %02h",
				$time, adr, got.dat, want.dat);
			stop_run();
		end
	endtask

	task automatic check_ready(input logic got, input logic want);
		if (got !== want) begin
			$display("Mismatch at time %0t: tape_ready got %b expected %b", $time, got, want);
			stop_run();
		end
	endtask

	// ==================================================
	// Bus drivers
	// ==================================================

	task automatic cpu_cycle(input logic we, input logic fetch, input logic [15:0] adr,
		input logic [7:0] dat, output zx81_pkg::bus_rsp_t rsp);
		zx81_pkg::cpu_req_t req;
		req.cyc   = 1'b1;
		req.stb   = 1'b1;
		req.we    = we;
		req.fetch = fetch;
		req.adr   = adr;
		req.dat   = dat;
		@(posedge clk_sys);
		cpu_req <= req;
		do begin
			@(negedge clk_sys);
		end while (!cpu_rsp.ack);
		rsp = cpu_rsp;
		@(posedge clk_sys);
		cpu_req <= '0;
	endtask

	task automatic download(input zx81_pkg::dl_target_t target, input logic [13:0] adr,
		input logic [7:0] dat, input logic last);
		zx81_pkg::dl_req_t req;
		req.cyc    = 1'b1;
		req.stb    = 1'b1;
		req.target = target;
		req.last   = last;
		req.adr    = adr;
		req.dat    = dat;
		@(posedge clk_sys);
		dl_req <= req;
		do begin
			@(negedge clk_sys);
		end while (!dl_ack);
		@(posedge clk_sys);
		dl_req <= '0;
	endtask

	task automatic apply_reset(input zx81_pkg::mem_size_t size);
		@(posedge clk_sys);
		reset    <= 1'b1;
		mem_size <= size;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	// Byte 1 of the patch reads 00h until the copy is done
	task automatic poll_fetch(input logic [15:0] adr, input logic [7:0] done_byte);
		zx81_pkg::bus_rsp_t rsp;
		zx81_pkg::bus_rsp_t wait_rsp;
		logic done;
		int polls;
		wait_rsp.ack = 1'b1;
		wait_rsp.dat = 8'h00;
		done  = 1'b0;
		polls = 0;
		while (!done && polls < TAPE_LEN * 16) begin
			cpu_cycle(1'b0, 1'b1, adr, 8'h00, rsp);
			polls++;
			if (rsp.ack === 1'b1 && rsp.dat === done_byte) begin
				done = 1'b1;
			end else begin
				check_rsp(adr, rsp, wait_rsp);
			end
		end
		if (!done) begin
			$display("Tape copy never finished, %04hh still reads 00h after %0d fetches",
				adr, polls);
			stop_run();
		end
	endtask

	// ==================================================
	// Stimulus table
	// ==================================================

	task automatic add_step(input step_kind_t kind, input logic [15:0] adr,
		input logic [7:0] dat, input logic [7:0] exp);
		step_t st;
		st.kind = kind;
		st.adr  = adr;
		st.dat  = dat;
		st.exp  = exp;
		steps.push_back(st);
	endtask

	task automatic build_table();
		logic [7:0] r0;
		logic [7:0] r1fff;
		logic [7:0] r347;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		draw_byte(r0);
		draw_byte(r1fff);
		draw_byte(r347);

		// Boot ROM checks start in 16K mode
		add_step(S_READY, 16'h0000, 8'h00, 8'h00);
		add_step(S_LOAD_ROM, 16'h0000, r0, 8'h00);
		add_step(S_LOAD_ROM, 16'h1FFF, r1fff, 8'h00);
		add_step(S_LOAD_ROM, 16'h0347, r347, 8'h00);
		add_step(S_READ, 16'h0000, 8'h00, r0);
		add_step(S_READ, 16'h1FFF, 8'h00, r1fff);
		add_step(S_READ, 16'h8000, 8'h00, r0);
		add_step(S_READ, 16'h9FFF, 8'h00, r1fff);
		add_step(S_WRITE, 16'h0000, ~r0, 8'h00);
		add_step(S_READ, 16'h0000, 8'h00, r0);
		add_step(S_READ, 16'h2000, 8'h00, 8'hFF);

		// 16K mode where C000h mirrors 4000h
		draw_byte(a);
		draw_byte(b);
		add_step(S_WRITE, 16'h4000, a, 8'h00);
		add_step(S_READ, 16'hC000, 8'h00, a);
		add_step(S_WRITE, 16'h7FFF, b, 8'h00);
		add_step(S_READ, 16'hFFFF, 8'h00, b);
		add_step(S_READ, 16'hA000, 8'h00, 8'hFF);
		add_step(S_READ, 16'h3FFF, 8'h00, 8'hFF);

		// 1K block repeats every 400h
		draw_byte(a);
		draw_byte(b);
		add_step(S_RESET, 16'h0000, 8'(zx81_pkg::MEM_1K), 8'h00);
		add_step(S_WRITE, 16'h4000, a, 8'h00);
		add_step(S_READ, 16'h4400, 8'h00, a);
		add_step(S_READ, 16'hC000, 8'h00, a);
		add_step(S_READ, 16'h7C00, 8'h00, a);
		add_step(S_WRITE, 16'h43FF, b, 8'h00);
		add_step(S_READ, 16'hFFFF, 8'h00, b);
		add_step(S_READ, 16'hA000, 8'h00, 8'hFF);

		// 32K mode with its own bank at 8000h
		draw_byte(a);
		draw_byte(b);
		draw_byte(c);
		add_step(S_RESET, 16'h0000, 8'(zx81_pkg::MEM_32K), 8'h00);
		add_step(S_WRITE, 16'h4000, a, 8'h00);
		add_step(S_WRITE, 16'h8000, b, 8'h00);
		add_step(S_READ, 16'h4000, 8'h00, a);
		add_step(S_READ, 16'h8000, 8'h00, b);
		add_step(S_READ, 16'hC000, 8'h00, a);
		add_step(S_WRITE, 16'hBFFF, c, 8'h00);
		add_step(S_READ, 16'hBFFF, 8'h00, c);
		add_step(S_READ, 16'h2000, 8'h00, 8'hFF);

		// 48K mode with a data only top bank
		draw_byte(a);
		draw_byte(b);
		draw_byte(c);
		add_step(S_RESET, 16'h0000, 8'(zx81_pkg::MEM_48K), 8'h00);
		add_step(S_WRITE, 16'h4000, a, 8'h00);
		add_step(S_WRITE, 16'hC000, b, 8'h00);
		add_step(S_READ, 16'hC000, 8'h00, b);
		add_step(S_FETCH, 16'hC000, 8'h00, a);
		add_step(S_READ, 16'h4000, 8'h00, a);
		add_step(S_WRITE, 16'h8000, c, 8'h00);
		add_step(S_READ, 16'h8000, 8'h00, c);
		add_step(S_READ, 16'h3FFF, 8'h00, 8'hFF);

		// Tape image and the fast load
		for (int k = 0; k < TAPE_LEN; k++) begin
			draw_byte(tape_img[k]);
			add_step(S_LOAD_TAPE, 16'(k), tape_img[k], 8'h00);
		end
		add_step(S_READY, 16'h0000, 8'h00, 8'h01);
		add_step(S_FETCH, 16'h0347, 8'h00, 8'hAF);
		add_step(S_POLL, 16'h0348, 8'h00, 8'h37);
		for (int k = 0; k < TAPE_LEN; k++) begin
			add_step(S_READ, 16'h4009 + 16'(k), 8'h00, tape_img[k]);
		end
		add_step(S_READ, 16'h034A, 8'h00, 8'hFD);
		add_step(S_READ, 16'h034B, 8'h00, 8'hC3);
		add_step(S_READ, 16'h034C, 8'h00, 8'h07);
		add_step(S_READ, 16'h034D, 8'h00, 8'h02);
		add_step(S_FETCH, 16'h0000, 8'h00, r0);
		add_step(S_READ, 16'h0347, 8'h00, r347);
	endtask

	task automatic run_step(input step_t st);
		zx81_pkg::bus_rsp_t rsp;
		zx81_pkg::bus_rsp_t want;
		want.ack = 1'b1;
		want.dat = st.exp;
		case (st.kind)
			S_RESET:     apply_reset(zx81_pkg::mem_size_t'(st.dat[1:0]));
			S_LOAD_ROM:  download(zx81_pkg::DL_ROM, st.adr[13:0], st.dat, 1'b0);
			S_LOAD_TAPE: begin
				download(zx81_pkg::DL_TAPE, st.adr[13:0], st.dat, st.adr == TAPE_LEN - 1);
			end
			S_READY: begin
				@(negedge clk_sys);
				check_ready(tape_ready, st.exp[0]);
			end
			S_READ: begin
				cpu_cycle(1'b0, 1'b0, st.adr, 8'h00, rsp);
				check_rsp(st.adr, rsp, want);
			end
			S_WRITE: cpu_cycle(1'b1, 1'b0, st.adr, st.dat, rsp);
			S_FETCH: begin
				cpu_cycle(1'b0, 1'b1, st.adr, 8'h00, rsp);
				check_rsp(st.adr, rsp, want);
			end
			default: poll_fetch(st.adr, st.exp);
		endcase
	endtask

	// ==================================================
	// Main sequence and watchdog
	// ==================================================

	initial begin
		reset    = 1'b1;
		mem_size = zx81_pkg::MEM_16K;
		cpu_req  = '0;
		dl_req   = '0;
		build_table();
		table_built = 1'b1;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		foreach (steps[i]) begin
			run_step(steps[i]);
		end
		@(posedge clk_sys);
		if (dut0.ram0.bus_chk0.fail_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Protocol errors remained at the end of the run");
			stop_run();
		end
	end

	// Shared RAM protocol checker
	always @(posedge clk_sys) begin
		if (dut0.ram0.bus_chk0.fail_count != 0) begin
			$display("Wishbone protocol check failed on the shared RAM ports");
			stop_run();
		end
	end

	initial begin
		int limit;
		wait (table_built);
		limit = steps.size() * 64 + TAPE_LEN * 16;
		repeat (limit) @(posedge clk_sys);
		$display("Timeout: the run hung, not finished after %0d cycles", limit);
		stop_run();
	end

endmodule
